// File: corr_pkg.sv
// Shared sizes, sample and count types and frame layout, imported by every correlator module
`default_nettype none

package corr_pkg;

	localparam int NUM_INPUTS = 4;
	localparam int NUM_LAGS = 3; // Lags -1, 0 and +1
	localparam int NUM_BASELINES = 6;
	localparam int NUM_CORR = 18;
	localparam int SAMPLE_W = 4;
	localparam int COUNT_W = 16;
	localparam int MAX_COUNTS = 32000; // An accumulator freezes once it leaves this range

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [2*SAMPLE_W-1:0] product_t;
	typedef logic signed [COUNT_W-1:0] count_t;
	typedef logic [4:0] corr_index_t;
	typedef logic [15:0] integ_len_t;

	// Taps of one delay line
	typedef struct packed {
		sample_t cur;
		sample_t prev;
	} delay_taps_t;

	// Word i holds baseline i/3 at lag (i%3)-1
	typedef count_t [NUM_CORR-1:0] corr_frame_t;

	typedef struct packed {
		count_t value;
		corr_index_t index;
		logic last;
	} corr_word_t;

	typedef enum logic [0:0] {
		SER_IDLE,
		SER_SEND
	} ser_state_t;

endpackage

`default_nettype wire

// File: sample_delay_line.sv
// Two-tap delay line for one input, shifts in a sample on each strobe and feeds the correlator
`timescale 1ns/1ps
`default_nettype none

module sample_delay_line (
	input logic pllclk,
	input logic reset,
	input logic strobe,
	input corr_pkg::sample_t sample,
	output corr_pkg::delay_taps_t taps,
	output logic taps_valid
);

	// The lag products read prev on the very first sample, so both taps start at zero
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			taps.cur <= '0;
			taps.prev <= '0;
		end else if (strobe) begin
			taps.prev <= taps.cur;
			taps.cur <= sample;
		end
	end

	// One pulse per captured sample, aligned with the new taps
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			taps_valid <= 1'b0;
		end else begin
			taps_valid <= strobe;
		end
	end

endmodule

`default_nettype wire

// File: baseline_correlator.sv
// Multiplies the delay taps of every line pair at three lags and integrates them into frame counters
`timescale 1ns/1ps
`default_nettype none

module baseline_correlator (
	input logic pllclk,
	input logic reset,
	input corr_pkg::delay_taps_t [corr_pkg::NUM_INPUTS-1:0] taps,
	input logic taps_valid,
	input logic dump,
	output logic acc_update,
	output corr_pkg::corr_frame_t frame,
	output logic frame_ready
);

	import corr_pkg::*;

	product_t prod_next [NUM_CORR];
	product_t prod [NUM_CORR];
	logic prod_valid;
	count_t acc [NUM_CORR];

	// Pair (a,b) gets baseline number a*(2N-a-1)/2 + b-a-1, matching the frame order
	for (genvar a = 0; a < NUM_INPUTS - 1; a++) begin : g_line_a
		for (genvar b = a + 1; b < NUM_INPUTS; b++) begin : g_line_b
			localparam int BL = a * (2 * NUM_INPUTS - a - 1) / 2 + (b - a - 1);

			assign prod_next[BL*NUM_LAGS+0] = taps[a].prev * taps[b].cur; // Lag -1
			assign prod_next[BL*NUM_LAGS+1] = taps[a].cur * taps[b].cur;
			assign prod_next[BL*NUM_LAGS+2] = taps[a].cur * taps[b].prev; // Lag +1
		end
	end

	always_ff @(posedge pllclk) begin
		if (taps_valid) begin
			for (int i = 0; i < NUM_CORR; i++) begin
				prod[i] <= prod_next[i];
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			prod_valid <= 1'b0;
			acc_update <= 1'b0;
		end else begin
			prod_valid <= taps_valid;
			acc_update <= prod_valid;
		end
	end

	// A counter that has left the open range (-MAX_COUNTS, MAX_COUNTS) keeps its value
	// until the next dump, so a long integration saturates instead of wrapping
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			for (int i = 0; i < NUM_CORR; i++) begin
				acc[i] <= '0;
			end
		end else if (dump) begin
			for (int i = 0; i < NUM_CORR; i++) begin
				acc[i] <= '0;
			end
		end else if (prod_valid) begin
			for (int i = 0; i < NUM_CORR; i++) begin
				if (acc[i] > -MAX_COUNTS && acc[i] < MAX_COUNTS) begin
					acc[i] <= acc[i] + prod[i];
				end
			end
		end
	end

	// Snapshot taken on the same edge that clears the counters
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			frame <= '0;
		end else if (dump) begin
			for (int i = 0; i < NUM_CORR; i++) begin
				frame[i] <= acc[i];
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			frame_ready <= 1'b0;
		end else begin
			frame_ready <= dump;
		end
	end

endmodule

`default_nettype wire

// File: integration_timer.sv
// Counts accumulator updates and requests a frame dump once per integration period
`timescale 1ns/1ps
`default_nettype none

module integration_timer (
	input logic pllclk,
	input logic reset,
	input logic acc_update,
	input corr_pkg::integ_len_t integ_samples,
	output logic dump
);

	import corr_pkg::*;

	integ_len_t limit;
	integ_len_t count;
	logic last_update;

	// A zero length would never close, so it runs as one sample per integration
	assign limit = (integ_samples == '0) ? integ_len_t'(1) : integ_samples;

	assign last_update = (count >= limit - integ_len_t'(1));

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			count <= '0;
		end else if (acc_update) begin
			if (last_update) begin
				count <= '0; // Next integration starts from an empty count
			end else begin
				count <= count + integ_len_t'(1);
			end
		end
	end

	// Registered, so the dump lands one cycle after the closing update
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			dump <= 1'b0;
		end else begin
			dump <= acc_update && last_update;
		end
	end

endmodule

`default_nettype wire

// File: frame_serializer.sv
// Streams a captured correlation frame out one word per clock and flags frames that arrive too early
`timescale 1ns/1ps
`default_nettype none

module frame_serializer (
	input logic pllclk,
	input logic reset,
	input corr_pkg::corr_frame_t frame,
	input logic frame_ready,
	output corr_pkg::corr_word_t out_word,
	output logic out_valid,
	output logic overrun
);

	import corr_pkg::*;

	ser_state_t state;
	corr_frame_t frame_buf;
	corr_index_t sel;
	logic at_last;

	assign at_last = (sel == corr_index_t'(NUM_CORR - 1));

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			state <= SER_IDLE;
			sel <= '0;
			overrun <= 1'b0;
		end else begin
			case (state)
				SER_IDLE: begin
					if (frame_ready) begin
						state <= SER_SEND;
						sel <= '0;
					end
				end
				SER_SEND: begin
					// No room for a second frame, it is dropped and the loss is remembered
					if (frame_ready) begin
						overrun <= 1'b1;
					end
					if (at_last) begin
						state <= SER_IDLE;
						sel <= '0;
					end else begin
						sel <= sel + corr_index_t'(1);
					end
				end
				default: begin
					state <= SER_IDLE;
					sel <= '0;
				end
			endcase
		end
	end

	// Private copy so the correlator can dump again while this one is on the wire
	always_ff @(posedge pllclk) begin
		if (state == SER_IDLE && frame_ready) begin
			frame_buf <= frame;
		end
	end

	assign out_valid = (state == SER_SEND);

	always_comb begin
		out_word.value = frame_buf[sel];
		out_word.index = sel;
		out_word.last = at_last; // Marks index 17
	end

endmodule

`default_nettype wire

// File: correlator_top.sv
// Top level of the four-input cross-correlator, wires delay lines, correlator, timer and serializer
`timescale 1ns/1ps
`default_nettype none

module correlator_top (
	input logic pllclk,
	input logic reset,
	input corr_pkg::sample_t [corr_pkg::NUM_INPUTS-1:0] sample_in,
	input logic [corr_pkg::NUM_INPUTS-1:0] sample_strobe,
	input corr_pkg::integ_len_t integ_samples,
	output corr_pkg::corr_word_t out_word,
	output logic out_valid,
	output logic overrun
);

	import corr_pkg::*;

	delay_taps_t [NUM_INPUTS-1:0] taps;
	logic [NUM_INPUTS-1:0] taps_valid;
	logic acc_update;
	logic dump;
	corr_frame_t frame;
	logic frame_ready;

	for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_line
		sample_delay_line u_sample_delay_line (
			.pllclk(pllclk),
			.reset(reset),
			.strobe(sample_strobe[i]),
			.sample(sample_in[i]),
			.taps(taps[i]),
			.taps_valid(taps_valid[i])
		);
	end

	// All strobes arrive together, so line 0 paces the whole array
	baseline_correlator u_baseline_correlator (
		.pllclk(pllclk),
		.reset(reset),
		.taps(taps),
		.taps_valid(taps_valid[0]),
		.dump(dump),
		.acc_update(acc_update),
		.frame(frame),
		.frame_ready(frame_ready)
	);

	integration_timer u_integration_timer (
		.pllclk(pllclk),
		.reset(reset),
		.acc_update(acc_update),
		.integ_samples(integ_samples),
		.dump(dump)
	);

	frame_serializer u_frame_serializer (
		.pllclk(pllclk),
		.reset(reset),
		.frame(frame),
		.frame_ready(frame_ready),
		.out_word(out_word),
		.out_valid(out_valid),
		.overrun(overrun)
	);

endmodule

`default_nettype wire

// File: correlator_asserts.sv
// Protocol checks on the correlator top level, bound into correlator_top by the testbench build
`timescale 1ns/1ps
`default_nettype none

module correlator_asserts (
	input logic pllclk,
	input logic reset,
	input logic out_valid,
	input logic dump,
	input logic acc_update,
	input logic overrun
);

	logic [4:0] valid_run; // Cycles out_valid has been high before this edge

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			valid_run <= '0;
		end else if (out_valid) begin
			valid_run <= valid_run + 5'd1;
		end else begin
			valid_run <= '0;
		end
	end

	// A frame is exactly 18 words, so a longer burst means the serializer lost its index
	valid_burst_len: assert property (@(posedge pllclk) disable iff (!reset)
		out_valid |-> valid_run < 5'd18)
		else $error("out_valid stayed high for more than 18 cycles");

	single_dump: assert property (@(posedge pllclk) disable iff (!reset) dump |=> !dump)
		else $error("dump was high on two consecutive cycles");

	update_dump_apart: assert property (@(posedge pllclk) disable iff (!reset)
		!(acc_update && dump))
		else $error("acc_update and dump were high together");

	overrun_sticky: assert property (@(posedge pllclk) disable iff (!reset) !$fell(overrun))
		else $error("overrun fell while reset was released");

endmodule

bind correlator_top correlator_asserts u_correlator_asserts (
	.pllclk(pllclk),
	.reset(reset),
	.out_valid(out_valid),
	.dump(dump),
	.acc_update(acc_update),
	.overrun(overrun)
);

`default_nettype wire

// File: tb_clock.sv
// Testbench clock and reset source, instantiated once by the correlator testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic pllclk,
	output logic reset
);

	initial begin
		pllclk = 1'b0;
		forever #50 pllclk = ~pllclk; // 100 ns period
	end

	// Reset held low for three rising edges, released on a falling edge
	initial begin
		reset = 1'b0;
		repeat (3) @(posedge pllclk);
		@(negedge pllclk);
		reset = 1'b1;
	end

endmodule

`default_nettype wire

// File: correlator_tb.sv
// Directed testbench for correlator_top, checks frames against a behavioral correlation model
`timescale 1ns/1ps
`default_nettype none

module correlator_tb;

	import corr_pkg::*;

	localparam int STROBE_GAP = 6;
	localparam int FRAME_WAIT = 40;
	localparam int TOTAL_SAMPLES = 8 + 4 + 60 + 600 + 2;
	localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 10 + 2000;

	logic pllclk;
	logic reset;
	sample_t [NUM_INPUTS-1:0] sample_in;
	logic [NUM_INPUTS-1:0] sample_strobe;
	integ_len_t integ_samples;
	corr_word_t out_word;
	logic out_valid;
	logic overrun;

	int error_count;
	integer seed;
	int model_cur [NUM_INPUTS];
	int model_prev [NUM_INPUTS];
	int model_acc [NUM_CORR];
	int exp_frame [NUM_CORR];
	int got_frame [NUM_CORR];

	tb_clock u_tb_clock (
		.pllclk(pllclk),
		.reset(reset)
	);

	correlator_top u_correlator_top (
		.pllclk(pllclk),
		.reset(reset),
		.sample_in(sample_in),
		.sample_strobe(sample_strobe),
		.integ_samples(integ_samples),
		.out_word(out_word),
		.out_valid(out_valid),
		.overrun(overrun)
	);

	task automatic compare_value(input int got, input int exp, input string what);
		assert (got == exp) else begin
			error_count++;
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			error_count++;
			$display("FAILED at %0t: %s", $time, what);
		end
	endtask

	// Baselines in pair order, lags -1, 0, +1, and no add once a counter leaves the open range
	function automatic void model_push(input sample_t [NUM_INPUTS-1:0] s);
		int bl;
		int prod [NUM_LAGS];
		bl = 0;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			model_prev[i] = model_cur[i];
			model_cur[i] = $signed(s[i]);
		end
		for (int a = 0; a < NUM_INPUTS - 1; a++) begin
			for (int b = a + 1; b < NUM_INPUTS; b++) begin
				prod[0] = model_prev[a] * model_cur[b];
				prod[1] = model_cur[a] * model_cur[b];
				prod[2] = model_cur[a] * model_prev[b];
				for (int lag = 0; lag < NUM_LAGS; lag++) begin
					if (model_acc[bl*NUM_LAGS+lag] > -MAX_COUNTS &&
							model_acc[bl*NUM_LAGS+lag] < MAX_COUNTS) begin
						model_acc[bl*NUM_LAGS+lag] += prod[lag];
					end
				end
				bl++;
			end
		end
	endfunction

	function automatic void clear_model_acc();
		for (int i = 0; i < NUM_CORR; i++) begin
			model_acc[i] = 0;
		end
	endfunction

	function automatic void close_integration();
		for (int i = 0; i < NUM_CORR; i++) begin
			exp_frame[i] = model_acc[i];
		end
		clear_model_acc();
	endfunction

	// One strobe on all lines, returns just before the next strobe slot
	task automatic send_sample(input sample_t [NUM_INPUTS-1:0] s);
		@(negedge pllclk);
		sample_in = s;
		sample_strobe = '1;
		@(negedge pllclk);
		sample_strobe = '0;
		repeat (STROBE_GAP - 2) @(negedge pllclk);
	endtask

	task automatic collect_frame();
		int waited;
		waited = 0;
		while (!out_valid && waited < FRAME_WAIT) begin
			@(negedge pllclk);
			waited++;
		end
		if (!out_valid) begin
			error_count++;
			$display("No frame appeared on out_valid within %0d cycles", FRAME_WAIT);
		end else begin
			for (int i = 0; i < NUM_CORR; i++) begin
				check_flag(out_valid, $sformatf("out_valid dropped before word %0d", i));
				compare_value(int'(out_word.index), i, "word index");
				compare_value(int'(out_word.last), (i == NUM_CORR - 1) ? 1 : 0,
					$sformatf("last flag of word %0d", i));
				got_frame[i] = $signed(out_word.value);
				compare_value(got_frame[i], exp_frame[i], $sformatf("value of word %0d", i));
				@(negedge pllclk);
			end
			check_flag(!out_valid, "out_valid still high after word 17");
		end
	endtask

	task automatic idle_after_reset();
		repeat (20) begin
			@(negedge pllclk);
			check_flag(!out_valid && !overrun, "out_valid or overrun high while idle");
		end
	endtask

	task automatic constant_samples();
		int c [NUM_INPUTS] = '{3, -2, 5, -7};
		sample_t [NUM_INPUTS-1:0] s;
		int bl;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			s[i] = sample_t'(c[i]);
		end
		integ_samples = 16'd8;
		repeat (8) begin
			model_push(s);
			send_sample(s);
		end
		close_integration();
		collect_frame();
		// Lags +1 and -1 miss one product, the first sample's prev tap is still zero
		bl = 0;
		for (int a = 0; a < NUM_INPUTS - 1; a++) begin
			for (int b = a + 1; b < NUM_INPUTS; b++) begin
				compare_value(got_frame[bl*3], 7 * c[a] * c[b], "constant lag -1");
				compare_value(got_frame[bl*3+1], 8 * c[a] * c[b], "constant lag 0");
				compare_value(got_frame[bl*3+2], 7 * c[a] * c[b], "constant lag +1");
				bl++;
			end
		end
	endtask

	task automatic impulse_lag();
		sample_t [NUM_INPUTS-1:0] s;
		integ_samples = 16'd4;
		for (int step = 0; step < 4; step++) begin
			s = '0;
			if (step == 1) begin
				s[0] = sample_t'(5);
			end else if (step == 2) begin
				s[1] = sample_t'(-3); // Line 1 follows line 0 by one sample
			end
			model_push(s);
			send_sample(s);
		end
		close_integration();
		collect_frame();
		for (int i = 0; i < NUM_CORR; i++) begin
			compare_value(got_frame[i], (i == 0) ? -15 : 0, $sformatf("impulse bin %0d", i));
		end
	endtask

	task automatic random_integrations();
		sample_t [NUM_INPUTS-1:0] s;
		integ_samples = 16'd20;
		for (int integ = 0; integ < 3; integ++) begin
			repeat (20) begin
				for (int i = 0; i < NUM_INPUTS; i++) begin
					s[i] = sample_t'($random(seed));
				end
				model_push(s);
				send_sample(s);
			end
			close_integration(); // Model restarts from zero, as the DUT must
			collect_frame();
		end
	endtask

	task automatic saturation_freeze();
		sample_t [NUM_INPUTS-1:0] s;
		s = {NUM_INPUTS{sample_t'(-8)}};
		integ_samples = 16'd600;
		repeat (600) begin
			model_push(s);
			send_sample(s);
		end
		close_integration();
		collect_frame();
		for (int bl = 0; bl < NUM_BASELINES; bl++) begin
			compare_value(got_frame[bl*3+1], MAX_COUNTS, "frozen lag 0 count");
		end
	endtask

	task automatic overrun_on_busy();
		sample_t [NUM_INPUTS-1:0] first;
		sample_t [NUM_INPUTS-1:0] second;
		first = {sample_t'(2), sample_t'(-1), sample_t'(4), sample_t'(1)};
		second = {sample_t'(-5), sample_t'(6), sample_t'(-3), sample_t'(7)};
		integ_samples = 16'd1;
		model_push(first);
		close_integration();
		model_push(second);
		clear_model_acc(); // Second frame is dropped by the serializer
		fork
			begin
				send_sample(first);
				send_sample(second);
			end
			collect_frame();
		join
		check_flag(overrun, "overrun not set after a frame arrived during sending");
		repeat (30) begin
			@(negedge pllclk);
			check_flag(overrun && !out_valid, "overrun cleared or dropped frame was sent");
		end
	endtask

	initial begin
		error_count = 0;
		seed = 32'h61b8_5610;
		sample_in = '0;
		sample_strobe = '0;
		integ_samples = 16'd1;
		@(posedge reset);
		@(negedge pllclk);
		idle_after_reset();
		constant_samples();
		impulse_lag();
		random_integrations();
		saturation_freeze();
		overrun_on_busy();
		$display("Checks finished with %0d errors", error_count);
		if (error_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge pllclk);
		$display("Watchdog expired after %0d cycles, the tests did not complete",
			WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
corr_pkg.sv
sample_delay_line.sv
baseline_correlator.sv
integration_timer.sv
frame_serializer.sv
correlator_top.sv
correlator_asserts.sv
tb_clock.sv
correlator_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the correlator testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module correlator_tb -o correlator_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/correlator_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
	echo "No pass message found in $LOG"
	exit 1
fi
exit 0
